//--- align/align_r.sv
module align_r
#(
   parameter IN_P_DW_BYTES  = 0,                            // log2 of bytes on the input side
   parameter IN_AW          = 0,                            // width of the byte address
   parameter OUT_P_DW_BYTES = 0                             // log2 of bytes on the output side
)
(
   input  logic [(1<<IN_P_DW_BYTES)*8-1:0]   i_dat,
   input  logic [(1<<IN_P_DW_BYTES)-1:0]     i_be,
   input  logic [IN_AW-1:0]                  i_addr,
   output logic [(1<<OUT_P_DW_BYTES)-1:0]    o_be,
   output logic [(1<<OUT_P_DW_BYTES)*8-1:0]  o_dat
);
   localparam int IN_BYTES  = 1 << IN_P_DW_BYTES;
   localparam int OUT_BYTES = 1 << OUT_P_DW_BYTES;

   // three shapes are possible and only one of them is built
   generate
      if (OUT_P_DW_BYTES == IN_P_DW_BYTES)
      begin : g_pass
         // same width on both sides so the word goes straight through
         assign o_dat = i_dat;
         assign o_be  = i_be;
      end
      else if (OUT_P_DW_BYTES < IN_P_DW_BYTES)
      begin : g_narrow
         localparam int SEL_W = IN_P_DW_BYTES - OUT_P_DW_BYTES;

         logic [SEL_W-1:0] lane;                            // which narrow lane the address hits

         // the lane number sits right above the byte offset of the narrow side
         assign lane  = i_addr[OUT_P_DW_BYTES +: SEL_W];

         assign o_dat = i_dat[lane*OUT_BYTES*8 +: OUT_BYTES*8];
         assign o_be  = i_be[lane*OUT_BYTES +: OUT_BYTES];  // enables follow the same lane
      end
      else
      begin : g_widen
         localparam int SEL_W = OUT_P_DW_BYTES - IN_P_DW_BYTES;
         localparam int LANES = 1 << SEL_W;

         logic [SEL_W-1:0] lane;

         assign lane = i_addr[IN_P_DW_BYTES +: SEL_W];

         // every lane carries a copy of the narrow word
         // but only the addressed lane gets its enables
         for (genvar l = 0; l < LANES; l++)
         begin : g_lane
            assign o_dat[l*IN_BYTES*8 +: IN_BYTES*8] = i_dat;
            assign o_be[l*IN_BYTES +: IN_BYTES]      = (lane == SEL_W'(l)) ? i_be : '0;
         end
      end
   endgenerate

endmodule

//--- align/align_w.sv
module align_w
#(
   parameter IN_P_DW_BYTES  = 0,                            // log2 of host bytes
   parameter IN_AW          = 0,
   parameter OUT_P_DW_BYTES = 0                             // log2 of memory bytes, never below the host
)
(
   input  logic [(1<<IN_P_DW_BYTES)*8-1:0]   i_dat,
   input  logic [(1<<IN_P_DW_BYTES)-1:0]     i_be,
   input  logic [IN_AW-1:0]                  i_addr,
   output logic [(1<<OUT_P_DW_BYTES)*8-1:0]  o_dat,
   output logic [(1<<OUT_P_DW_BYTES)-1:0]    o_be
);
   localparam int IN_BYTES = 1 << IN_P_DW_BYTES;
   localparam int SEL_W    = OUT_P_DW_BYTES - IN_P_DW_BYTES; // address bits that pick the lane

   // the write path only ever widens, a narrower memory is outside this bridge
   generate
      if (SEL_W == 0)
      begin : g_pass
         assign o_dat = i_dat;
         assign o_be  = i_be;
      end
      else
      begin : g_widen
         localparam int LANES = 1 << SEL_W;

         logic [SEL_W-1:0] lane;

         assign lane = i_addr[IN_P_DW_BYTES +: SEL_W];       // lane index above the host byte offset

         always_comb
         begin
            for (int l = 0; l < LANES; l++)
            begin
               // data lands in all lanes and the memory keeps only the strobed bytes
               o_dat[l*IN_BYTES*8 +: IN_BYTES*8] = i_dat;
               if (int'(lane) == l)
                  o_be[l*IN_BYTES +: IN_BYTES] = i_be;
               else
                  o_be[l*IN_BYTES +: IN_BYTES] = '0;       // other lanes stay untouched
            end
         end
      end
   endgenerate

endmodule

//--- bench/bridge_properties.sv
module bridge_properties
(
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_psel,
   input  logic               i_penable,
   input  bridge_pkg::addr_t  i_paddr,
   input  logic               i_pready,                    // the bridge's o_pready
   input  logic               i_pslverr                    // the bridge's o_pslverr
);
   int fail_count = 0;                                     // protocol violations seen so far

   // pready may only answer an access phase, never a setup or an idle cycle
   ready_in_access: assert property (@(posedge clk) disable iff (i_rst)
      i_pready |-> (i_psel && i_penable))
      else
      begin
         $error("pready was raised outside an access phase");
         fail_count++;
      end

   // an error response is part of a completing cycle
   slverr_with_ready: assert property (@(posedge clk) disable iff (i_rst)
      i_pslverr |-> i_pready)
      else
      begin
         $error("pslverr was raised without pready");
         fail_count++;
      end

   // the requester may not move the address before the bridge has answered
   addr_held: assert property (@(posedge clk) disable iff (i_rst)
      (i_psel && !i_pready) |=> $stable(i_paddr))
      else
      begin
         $error("paddr changed before the transfer completed");
         fail_count++;
      end

endmodule

// the checker watches only the host side of the top level
bind apb_width_bridge bridge_properties u_props
(
   .clk       (clk),
   .i_rst     (i_rst),
   .i_psel    (i_psel),
   .i_penable (i_penable),
   .i_paddr   (i_paddr),
   .i_pready  (o_pready),
   .i_pslverr (o_pslverr)
);

//--- bench/bridge_tb.sv
module bridge_tb;

   localparam int DRV_DELAY     = 5;                       // inputs change this long after a rising edge
   localparam int READY_TIMEOUT = 40;                      // cycles an access phase may wait for pready
   localparam int SPACE_BYTES   = 2048;                    // size of the decoded window

   // one row of the operation table
   typedef struct packed
   {
      logic                   write;
      logic                   rnd;                         // data is replaced by the next random word
      logic                   exp_err;                     // pslverr is expected for this access
      bridge_pkg::addr_t      addr;
      bridge_pkg::host_data_t data;
      bridge_pkg::host_be_t   strb;
   } op_t;

   logic                   clk = 1'b0;
   logic                   i_rst;
   logic                   i_psel;
   logic                   i_penable;
   logic                   i_pwrite;
   bridge_pkg::addr_t      i_paddr;
   bridge_pkg::host_data_t i_pwdata;
   bridge_pkg::host_be_t   i_pstrb;
   logic                   o_pready;
   bridge_pkg::host_data_t o_prdata;
   logic                   o_pslverr;

   op_t         ops [$];
   logic [7:0]  ref_mem [SPACE_BYTES];                     // byte image of what the memory should hold
   logic [31:0] rng_state = 32'h2440_c7d3;
   int          checks    = 0;
   int          errors    = 0;
   int          timeouts  = 0;
   logic        hung      = 1'b0;                          // set once an access never completed

   apb_width_bridge uut (.clk(clk), .i_rst(i_rst), .i_psel(i_psel), .i_penable(i_penable),
      .i_pwrite(i_pwrite), .i_paddr(i_paddr), .i_pwdata(i_pwdata), .i_pstrb(i_pstrb),
      .o_pready(o_pready), .o_prdata(o_prdata), .o_pslverr(o_pslverr));

   always #20 clk = ~clk;                                  // period of 40

   // xorshift32 so that the random words repeat from run to run
   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic in_window(input bridge_pkg::addr_t addr);
      return (int'(addr) < SPACE_BYTES);                   // upper address bits all zero
   endfunction

   // the host word sits on a 4-byte boundary and the low two address bits are ignored
   function automatic int word_base(input bridge_pkg::addr_t addr);
      return int'(addr) & (SPACE_BYTES - 4);
   endfunction

   function automatic logic [31:0] expected_word(input bridge_pkg::addr_t addr);
      int b;
      b = word_base(addr);
      return {ref_mem[b + 3], ref_mem[b + 2], ref_mem[b + 1], ref_mem[b]};
   endfunction

   task automatic model_write(input bridge_pkg::addr_t addr, input logic [31:0] data,
                              input logic [3:0] strb);
      int b;
      b = word_base(addr);
      for (int k = 0; k < 4; k++)
      begin
         if (strb[k])
            ref_mem[b + k] = data[k*8 +: 8];               // only strobed bytes change
      end
   endtask

   task automatic put_op(input logic write, input bridge_pkg::addr_t addr,
                         input logic [31:0] data, input logic [3:0] strb, input logic rnd,
                         input logic exp_err);
      op_t op;
      op.write   = write;
      op.rnd     = rnd;
      op.exp_err = exp_err;
      op.addr    = addr;
      op.data    = data;
      op.strb    = strb;
      ops.push_back(op);
   endtask

   // starts at a drive point and leaves the bus idle at the next one,
   // so a following call runs back to back with no idle cycle
   task automatic apb_transfer(input logic write, input bridge_pkg::addr_t addr,
                               input logic [31:0] wdata, input logic [3:0] strb,
                               output logic [31:0] rdata, output logic err);
      int   waited;
      logic seen;
      waited    = 0;
      seen      = 1'b0;
      rdata     = '0;
      err       = 1'b0;
      i_psel    = 1'b1;                                    // setup phase
      i_penable = 1'b0;
      i_pwrite  = write;
      i_paddr   = addr;
      i_pwdata  = wdata;
      i_pstrb   = strb;
      @(posedge clk);
      #DRV_DELAY i_penable = 1'b1;
      while (!seen && waited < READY_TIMEOUT)
      begin
         @(negedge clk);                                   // outputs have settled mid-cycle
         if (o_pready)
         begin
            seen  = 1'b1;
            rdata = o_prdata;
            err   = o_pslverr;
         end
         else
            waited++;
      end
      if (!seen)
      begin
         $display("timeout: no pready within %0d cycles for address %h", READY_TIMEOUT, addr);
         timeouts++;
         hung = 1'b1;
      end
      @(posedge clk);
      #DRV_DELAY;
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   task automatic apb_write(input bridge_pkg::addr_t addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic err);
      logic [31:0] unused;
      apb_transfer(1'b1, addr, data, strb, unused, err);
   endtask

   task automatic apb_read(input bridge_pkg::addr_t addr, output logic [31:0] data,
                           output logic err);
      apb_transfer(1'b0, addr, '0, '0, data, err);         // reads carry no strobes
   endtask

   task automatic check_idle(input int cycles);
      for (int c = 0; c < cycles; c++)
      begin
         @(negedge clk);
         checks++;
         assert (o_pready == 1'b0)
         else
         begin
            $display("** Error at %0t: o_pready expected 0, got %b", $time, o_pready);
            errors++;
         end
         assert (o_pslverr == 1'b0)
         else
         begin
            $display("** Error at %0t: o_pslverr expected 0, got %b", $time, o_pslverr);
            errors++;
         end
      end
   endtask

   task automatic load_table();
      // both halves of one word, each read back unchanged
      put_op(1, 16'h0010, 32'h1122_3344, 4'hf, 0, 0);
      put_op(1, 16'h0014, 32'h5566_7788, 4'hf, 0, 0);
      put_op(0, 16'h0010, 32'h0, 4'h0, 0, 0);
      put_op(0, 16'h0014, 32'h0, 4'h0, 0, 0);
      // partial strobes over a random background
      put_op(1, 16'h0020, 32'h0, 4'hf, 1, 0);
      put_op(1, 16'h0024, 32'h0, 4'hf, 1, 0);
      put_op(1, 16'h0020, 32'ha5a5_a5a5, 4'h5, 0, 0);
      put_op(1, 16'h0026, 32'hc3c3_c3c3, 4'ha, 0, 0);      // low address bits do not move the lane
      put_op(0, 16'h0020, 32'h0, 4'h0, 0, 0);
      put_op(0, 16'h0024, 32'h0, 4'h0, 0, 0);
      put_op(1, 16'h0023, 32'h0, 4'h8, 1, 0);
      put_op(0, 16'h0020, 32'h0, 4'h0, 0, 0);
      // back to back posted writes, the newest one must win
      put_op(1, 16'h0100, 32'h0, 4'hf, 1, 0);
      put_op(1, 16'h0104, 32'h0, 4'hf, 1, 0);
      put_op(1, 16'h0100, 32'h0, 4'hf, 1, 0);
      put_op(1, 16'h0104, 32'h0, 4'hf, 1, 0);
      put_op(1, 16'h0100, 32'h0, 4'hf, 1, 0);
      put_op(1, 16'h0104, 32'h0, 4'hf, 1, 0);
      put_op(0, 16'h0104, 32'h0, 4'h0, 0, 0);
      put_op(0, 16'h0100, 32'h0, 4'h0, 0, 0);
      // refused accesses above 2 KB leave their aliases alone
      put_op(1, 16'h0008, 32'h0, 4'hf, 1, 0);
      put_op(1, 16'h0808, 32'hdead_beef, 4'hf, 0, 1);
      put_op(0, 16'h0808, 32'h0, 4'h0, 0, 1);
      put_op(1, 16'hf810, 32'h0bad_0bad, 4'hf, 0, 1);
      put_op(0, 16'h0008, 32'h0, 4'h0, 0, 0);
      put_op(0, 16'h0010, 32'h0, 4'h0, 0, 0);
   endtask

   initial
   begin
      op_t         cur;
      logic [31:0] got_data;
      logic [31:0] exp_data;
      logic        got_err;
      i_rst     = 1'b1;
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
      i_paddr   = '0;
      i_pwdata  = '0;
      i_pstrb   = '0;
      for (int a = 0; a < SPACE_BYTES; a++)
         ref_mem[a] = 8'h00;
      load_table();
      repeat (4) @(posedge clk);
      #DRV_DELAY i_rst = 1'b0;
      check_idle(3);                                       // quiet bus right after reset
      for (int i = 0; i < ops.size() && !hung; i++)
      begin
         cur = ops[i];
         if (cur.rnd)
            cur.data = next_random();
         exp_data = expected_word(cur.addr);               // earlier writes have all been queued
         if (cur.write)
            apb_write(cur.addr, cur.data, cur.strb, got_err);
         else
            apb_read(cur.addr, got_data, got_err);
         if (!hung)
         begin
            checks++;
            assert (got_err == cur.exp_err)
            else
            begin
               $display("** Error at %0t: o_pslverr expected %b, got %b (addr %h)", $time,
                        cur.exp_err, got_err, cur.addr);
               errors++;
            end
            if (cur.write && in_window(cur.addr))
               model_write(cur.addr, cur.data, cur.strb);
            if (!cur.write && !cur.exp_err)
            begin
               checks++;
               assert (got_data == exp_data)
               else
               begin
                  $display("** Error at %0t: o_prdata expected %h, got %h (addr %h)", $time,
                           exp_data, got_data, cur.addr);
                  errors++;
               end
            end
         end
      end
      if (!hung)
         check_idle(3);
      $display("checks %0d, value errors %0d, timeouts %0d, protocol failures %0d", checks,
               errors, timeouts, uut.u_props.fail_count);
      if (errors == 0 && timeouts == 0 && uut.u_props.fail_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- common/bridge_pkg.sv
package bridge_pkg;

   // host side is 32-bit APB with a 16-bit byte address
   localparam int ADDR_W       = 16;
   localparam int HOST_P_BYTES = 2;                         // log2 of host data bytes
   localparam int MEM_P_BYTES  = 3;                         // log2 of memory word bytes
   localparam int MEM_IDX_W    = 8;                         // 256 words of 64 bits, 2 KB in all
   localparam int FIFO_DEPTH   = 4;

   localparam int HOST_BYTES = 1 << HOST_P_BYTES;
   localparam int MEM_BYTES  = 1 << MEM_P_BYTES;
   localparam int HOST_DW    = HOST_BYTES * 8;
   localparam int MEM_DW     = MEM_BYTES * 8;
   localparam int MEM_WORDS  = 1 << MEM_IDX_W;
   localparam int SPACE_AW   = MEM_IDX_W + MEM_P_BYTES;     // address bits inside the 2 KB space

   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);      // count must reach FIFO_DEPTH itself

   // a request entry carries the write data already widened to the memory lane layout
   // so it is packed as {write, addr, wide data, wide strobe} with the strobe at the bottom
   localparam int REQ_BE_LSB    = 0;
   localparam int REQ_DATA_LSB  = REQ_BE_LSB + MEM_BYTES;
   localparam int REQ_ADDR_LSB  = REQ_DATA_LSB + MEM_DW;
   localparam int REQ_WRITE_BIT = REQ_ADDR_LSB + ADDR_W;
   localparam int REQ_W         = REQ_WRITE_BIT + 1;        // 89 bits

   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [HOST_DW-1:0]   host_data_t;
   typedef logic [HOST_BYTES-1:0] host_be_t;
   typedef logic [MEM_DW-1:0]    mem_data_t;
   typedef logic [MEM_BYTES-1:0] mem_be_t;
   typedef logic [MEM_IDX_W-1:0] mem_idx_t;
   typedef logic [REQ_W-1:0]     req_word_t;

endpackage

//--- run.sh
#!/bin/sh
# build the bridge and its testbench, run it, and judge the run from the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module bridge_tb \
   -f vlog.f -o bridge_sim \
   && ./obj_dir/bridge_sim > sim.log 2>&1 \
   || echo "build or simulation stopped early"

cat sim.log 2>/dev/null

grep -q "NO ERRORS" sim.log 2>/dev/null && echo "run passed" || { echo "run failed"; exit 1; }

//--- source/apb_req_front.sv
module apb_req_front
(
   input  logic                    clk,
   input  logic                    i_rst,
   input  logic                    i_psel,
   input  logic                    i_penable,
   input  logic                    i_pwrite,
   input  bridge_pkg::addr_t       i_paddr,
   input  bridge_pkg::host_data_t  i_pwdata,
   input  bridge_pkg::host_be_t    i_pstrb,
   input  logic                    i_full,                  // request FIFO has no free slot
   input  logic                    i_rd_valid,              // memory read word is on i_rd_data
   input  bridge_pkg::host_data_t  i_rd_data,               // already narrowed to the host lane
   output logic                    o_pready,
   output bridge_pkg::host_data_t  o_prdata,
   output logic                    o_pslverr,
   output logic                    o_push,
   output logic                    o_push_write,
   output bridge_pkg::addr_t       o_push_addr,
   output bridge_pkg::host_data_t  o_push_data,
   output bridge_pkg::host_be_t    o_push_be
);
   // only this module walks through these states
   typedef enum logic [1:0]
   {
      ST_IDLE,                                             // waiting for an access phase
      ST_RD_WAIT,                                          // read is queued, waiting for its data
      ST_DONE                                              // pready went out, let the transfer close
   } state_t;

   state_t state;
   state_t state_nxt;
   logic   access;
   logic   in_range;

   assign access   = i_psel & i_penable;
   // anything above the 2 KB window is refused
   assign in_range = (i_paddr[bridge_pkg::ADDR_W-1:bridge_pkg::SPACE_AW] == '0);

   always_ff @(posedge clk)
   begin
      if (i_rst)
         state <= ST_IDLE;
      else
         state <= state_nxt;
   end

   // pready is decided in the same cycle so a posted write finishes in its first access cycle
   always_comb
   begin
      state_nxt = state;
      o_pready  = 1'b0;
      o_pslverr = 1'b0;
      o_prdata  = '0;
      o_push    = 1'b0;
      case (state)
         ST_IDLE:
         begin
            if (access)
            begin
               if (!in_range)
               begin
                  o_pready  = 1'b1;                        // refused at once, nothing is queued
                  o_pslverr = 1'b1;
                  state_nxt = ST_DONE;
               end
               else if (!i_full)
               begin
                  o_push = 1'b1;                           // both writes and reads go through the FIFO
                  if (i_pwrite)
                  begin
                     o_pready  = 1'b1;                     // write is posted
                     state_nxt = ST_DONE;
                  end
                  else
                     state_nxt = ST_RD_WAIT;
               end
               // a full FIFO simply holds pready low until a slot frees
            end
         end
         ST_RD_WAIT:
         begin
            // the read entry drains behind every earlier write before data returns
            if (i_rd_valid)
            begin
               o_pready  = 1'b1;
               o_prdata  = i_rd_data;
               state_nxt = ST_DONE;
            end
         end
         ST_DONE:
            state_nxt = ST_IDLE;                           // this cycle is the next setup phase at most
         default:
            state_nxt = ST_IDLE;
      endcase
   end

   // request fields come from the held APB address and control
   assign o_push_write = i_pwrite;
   assign o_push_addr  = i_paddr;
   assign o_push_data  = i_pwdata;
   assign o_push_be    = i_pwrite ? i_pstrb : '0;          // a read never strobes a byte

endmodule

//--- source/apb_width_bridge.sv
module apb_width_bridge
(
   input  logic                    clk,
   input  logic                    i_rst,
   input  logic                    i_psel,
   input  logic                    i_penable,
   input  logic                    i_pwrite,
   input  bridge_pkg::addr_t       i_paddr,
   input  bridge_pkg::host_data_t  i_pwdata,
   input  bridge_pkg::host_be_t    i_pstrb,
   output logic                    o_pready,
   output bridge_pkg::host_data_t  o_prdata,
   output logic                    o_pslverr
);
   logic                   push;
   logic                   push_write;
   bridge_pkg::addr_t      push_addr;
   bridge_pkg::host_data_t push_data;
   bridge_pkg::host_be_t   push_be;
   bridge_pkg::mem_data_t  wide_data;                      // host word copied into both lanes
   bridge_pkg::mem_be_t    wide_be;                        // strobes only in the addressed lane
   bridge_pkg::req_word_t  push_word;
   bridge_pkg::req_word_t  pop_word;
   logic                   full;
   logic                   pop_valid;
   logic                   pop_ready;
   logic                   rd_valid;
   bridge_pkg::mem_data_t  rd_word;
   bridge_pkg::host_data_t rd_data;                        // the addressed 32-bit half

   apb_req_front u_front (.clk(clk), .i_rst(i_rst), .i_psel(i_psel), .i_penable(i_penable),
      .i_pwrite(i_pwrite), .i_paddr(i_paddr), .i_pwdata(i_pwdata), .i_pstrb(i_pstrb),
      .i_full(full), .i_rd_valid(rd_valid), .i_rd_data(rd_data), .o_pready(o_pready),
      .o_prdata(o_prdata), .o_pslverr(o_pslverr), .o_push(push), .o_push_write(push_write),
      .o_push_addr(push_addr), .o_push_data(push_data), .o_push_be(push_be));

   // widen before queueing so the FIFO entry already matches the memory lanes
   align_w #(.IN_P_DW_BYTES(bridge_pkg::HOST_P_BYTES), .IN_AW(bridge_pkg::ADDR_W),
      .OUT_P_DW_BYTES(bridge_pkg::MEM_P_BYTES)) u_align_w (.i_dat(push_data), .i_be(push_be),
      .i_addr(push_addr), .o_dat(wide_data), .o_be(wide_be));

   assign push_word = {push_write, push_addr, wide_data, wide_be};

   req_fifo u_fifo (.clk(clk), .i_rst(i_rst), .i_push(push), .i_push_word(push_word),
      .i_pop_ready(pop_ready), .o_full(full), .o_pop_valid(pop_valid), .o_pop_word(pop_word));

   wide_sram u_sram (.clk(clk), .i_rst(i_rst), .i_pop_valid(pop_valid), .i_pop_word(pop_word),
      .o_pop_ready(pop_ready), .o_rd_valid(rd_valid), .o_rd_word(rd_word));

   // the held APB address picks the half, all bytes of the word count as valid
   align_r #(.IN_P_DW_BYTES(bridge_pkg::MEM_P_BYTES), .IN_AW(bridge_pkg::ADDR_W),
      .OUT_P_DW_BYTES(bridge_pkg::HOST_P_BYTES)) u_align_r (.i_dat(rd_word),
      .i_be({bridge_pkg::MEM_BYTES{1'b1}}), .i_addr(push_addr), .o_be(), .o_dat(rd_data));

endmodule

//--- source/req_fifo.sv
module req_fifo
(
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_push,
   input  bridge_pkg::req_word_t  i_push_word,
   input  logic                   i_pop_ready,
   output logic                   o_full,
   output logic                   o_pop_valid,
   output bridge_pkg::req_word_t  o_pop_word
);
   localparam int PTR_W = bridge_pkg::FIFO_PTR_W;
   localparam int CNT_W = bridge_pkg::FIFO_CNT_W;
   localparam int DEPTH = bridge_pkg::FIFO_DEPTH;

   bridge_pkg::req_word_t slots [DEPTH];                   // entry storage, no reset needed
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [CNT_W-1:0]      count;                           // entries currently held
   logic                  do_push;
   logic                  do_pop;

   assign do_push     = i_push & ~o_full;                  // a push into a full queue is dropped
   assign do_pop      = o_pop_valid & i_pop_ready;
   assign o_full      = (count == CNT_W'(DEPTH));
   assign o_pop_valid = (count != '0);                     // valid the cycle after the first push
   assign o_pop_word  = slots[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_push)
         slots[wr_ptr] <= i_push_word;
   end

   // pointers wrap at the last slot so any depth works
   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_rst)
         count <= '0;
      else
      begin
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                       // both or neither leave the level alone
         endcase
      end
   end

endmodule

//--- source/wide_sram.sv
module wide_sram
(
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_pop_valid,
   input  bridge_pkg::req_word_t  i_pop_word,
   output logic                   o_pop_ready,
   output logic                   o_rd_valid,
   output bridge_pkg::mem_data_t  o_rd_word
);
   bridge_pkg::mem_data_t mem [bridge_pkg::MEM_WORDS];    // the 2 KB array itself
   logic                  e_write;
   bridge_pkg::mem_idx_t  e_idx;
   bridge_pkg::mem_data_t e_data;
   bridge_pkg::mem_be_t   e_be;
   logic                  do_pop;

   // pull the fields out of the queued entry
   assign e_write = i_pop_word[bridge_pkg::REQ_WRITE_BIT];
   // the word index drops the byte offset inside the 64-bit word
   assign e_idx   = i_pop_word[bridge_pkg::REQ_ADDR_LSB + bridge_pkg::MEM_P_BYTES
                               +: bridge_pkg::MEM_IDX_W];
   assign e_data  = i_pop_word[bridge_pkg::REQ_DATA_LSB +: bridge_pkg::MEM_DW];
   assign e_be    = i_pop_word[bridge_pkg::REQ_BE_LSB +: bridge_pkg::MEM_BYTES];

   // the array finishes any entry in one cycle so it never stalls the FIFO
   assign o_pop_ready = 1'b1;
   assign do_pop      = i_pop_valid & o_pop_ready;

   // byte lanes are written only where the strobe is set
   always_ff @(posedge clk)
   begin
      if (do_pop && e_write)
      begin
         for (int b = 0; b < bridge_pkg::MEM_BYTES; b++)
         begin
            if (e_be[b])
               mem[e_idx][b*8 +: 8] <= e_data[b*8 +: 8];
         end
      end
   end

   // whole word is read back and the top picks the host lane
   always_ff @(posedge clk)
   begin
      if (do_pop && !e_write)
         o_rd_word <= mem[e_idx];
   end

   always_ff @(posedge clk)
   begin
      if (i_rst)
         o_rd_valid <= 1'b0;
      else
         o_rd_valid <= do_pop & ~e_write;                  // one cycle after the read pops
   end

endmodule

//--- vlog.f
common/bridge_pkg.sv
align/align_r.sv
align/align_w.sv
source/apb_req_front.sv
source/req_fifo.sv
source/wide_sram.sv
source/apb_width_bridge.sv
bench/bridge_properties.sv
bench/bridge_tb.sv
